// ==== logic/rob_pkg.sv ====
package rob_pkg;

    // one machine word, data or address
    typedef logic [31:0] xlen_t;

    // architectural register number
    typedef logic [4:0] reg_idx_t;

    // tag sized for the largest buffer, 16 entries
    localparam int ROB_TAG_W = 4;

    // index of one buffer entry
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // default entry count
    // top level passes it down as DEPTH
    localparam int ROB_DEPTH = 8;

    // what the entry does when it reaches the head
    typedef enum logic [1:0] {
        // result written to rd
        KIND_REG    = 2'd0,
        // memory write with handshake
        KIND_STORE  = 2'd1,
        // conditional branch, checked against prediction
        KIND_BRANCH = 2'd2
    } entry_kind_t;

    // store width
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_t;

endpackage

// ==== logic/rob_alloc_ctrl.sv ====
`timescale 1ns/1ps

module rob_alloc_ctrl #(
    parameter int DEPTH = 8
) (
    input  logic              alu_broadcast,
    input  logic              rst_n,
    input  logic              disp_valid,
    input  logic              retire,
    input  logic              flush,
    output logic              disp_ready,
    output rob_pkg::rob_tag_t head_tag,
    output rob_pkg::rob_tag_t tail_tag
);
    import rob_pkg::*;

    // count runs 0..DEPTH, one bit wider than the index
    localparam int CNT_W = $clog2(DEPTH) + 1;
    // last legal tag, pointers wrap after it
    localparam rob_tag_t LAST_TAG = rob_tag_t'(DEPTH - 1);

    logic [CNT_W-1:0] count;
    logic             accept;

    // no room when every entry is taken
    // flush cycle also blocks, pointers are being cleared
    assign disp_ready = (count != CNT_W'(DEPTH)) && !flush;
    assign accept     = disp_valid && disp_ready;

    always_ff @(posedge alu_broadcast or negedge rst_n) begin
        if (!rst_n) begin
            head_tag <= '0;
            tail_tag <= '0;
            count    <= '0;
        end else if (flush) begin
            // mispredict, drop everything, tags restart at 0
            head_tag <= '0;
            tail_tag <= '0;
            count    <= '0;
        end else begin
            if (accept) begin
                tail_tag <= (tail_tag == LAST_TAG) ? '0 : tail_tag + 1'b1;
            end
            if (retire) begin
                head_tag <= (head_tag == LAST_TAG) ? '0 : head_tag + 1'b1;
            end
            // occupancy, dispatch and retire in the same cycle cancel out
            case ({accept, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== logic/rob_entry_table.sv ====
`timescale 1ns/1ps

module rob_entry_table #(
    parameter int DEPTH = 8
) (
    input  logic                 alu_broadcast,
    input  logic                 rst_n,
    // dispatch write at the tail
    input  logic                 disp_we,
    input  rob_pkg::rob_tag_t    tail_tag,
    input  rob_pkg::entry_kind_t disp_kind,
    input  rob_pkg::reg_idx_t    disp_rd,
    input  rob_pkg::mem_size_t   disp_size,
    input  rob_pkg::xlen_t       disp_pc,
    input  logic                 disp_pred_taken,
    // alu result bus
    input  logic                 alu_wb_valid,
    input  rob_pkg::rob_tag_t    alu_wb_tag,
    input  rob_pkg::xlen_t       alu_wb_value,
    input  rob_pkg::xlen_t       alu_wb_target,
    // load/store result bus
    input  logic                 lsb_wb_valid,
    input  rob_pkg::rob_tag_t    lsb_wb_tag,
    input  rob_pkg::xlen_t       lsb_wb_value,
    input  rob_pkg::xlen_t       lsb_wb_addr,
    // head side
    input  rob_pkg::rob_tag_t    head_tag,
    input  logic                 retire,
    input  logic                 flush,
    output logic                 head_ready,
    output rob_pkg::entry_kind_t head_kind,
    output rob_pkg::reg_idx_t    head_rd,
    output rob_pkg::mem_size_t   head_size,
    output rob_pkg::xlen_t       head_pc,
    output logic                 head_pred_taken,
    output rob_pkg::xlen_t       head_value,
    output rob_pkg::xlen_t       head_target,
    output rob_pkg::xlen_t       head_addr
);
    import rob_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    // per-entry fields
    entry_kind_t kind_q   [DEPTH];
    reg_idx_t    rd_q     [DEPTH];
    mem_size_t   size_q   [DEPTH];
    xlen_t       pc_q     [DEPTH];
    logic        pred_q   [DEPTH];
    xlen_t       value_q  [DEPTH];
    xlen_t       target_q [DEPTH];
    xlen_t       addr_q   [DEPTH];
    logic [DEPTH-1:0] ready_q;

    // tags never exceed DEPTH-1, low bits are the array index
    logic [IDX_W-1:0] tail_idx;
    logic [IDX_W-1:0] head_idx;
    logic [IDX_W-1:0] alu_idx;
    logic [IDX_W-1:0] lsb_idx;

    assign tail_idx = tail_tag[IDX_W-1:0];
    assign head_idx = head_tag[IDX_W-1:0];
    assign alu_idx  = alu_wb_tag[IDX_W-1:0];
    assign lsb_idx  = lsb_wb_tag[IDX_W-1:0];

    always_ff @(posedge alu_broadcast) begin
        if (disp_we) begin
            kind_q[tail_idx] <= disp_kind;
            rd_q[tail_idx]   <= disp_rd;
            size_q[tail_idx] <= disp_size;
            pc_q[tail_idx]   <= disp_pc;
            pred_q[tail_idx] <= disp_pred_taken;
        end
        // result, or actual direction in bit 0 for a branch
        if (alu_wb_valid && !flush) begin
            value_q[alu_idx]  <= alu_wb_value;
            target_q[alu_idx] <= alu_wb_target;
        end
        // load data, or store data plus address
        if (lsb_wb_valid && !flush) begin
            value_q[lsb_idx] <= lsb_wb_value;
            addr_q[lsb_idx]  <= lsb_wb_addr;
        end
    end

    // ready bits double as the valid bits of the entries
    always_ff @(posedge alu_broadcast or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= '0;
        end else if (flush) begin
            // late writebacks of flushed entries are dropped here too
            ready_q <= '0;
        end else begin
            if (disp_we) begin
                ready_q[tail_idx] <= 1'b0;
            end
            if (retire) begin
                ready_q[head_idx] <= 1'b0;
            end
            // the two buses never share a tag in one cycle
            if (alu_wb_valid) begin
                ready_q[alu_idx] <= 1'b1;
            end
            if (lsb_wb_valid) begin
                ready_q[lsb_idx] <= 1'b1;
            end
        end
    end

    // head read-out, empty buffer shows as not ready
    assign head_ready      = ready_q[head_idx];
    assign head_kind       = kind_q[head_idx];
    assign head_rd         = rd_q[head_idx];
    assign head_size       = size_q[head_idx];
    assign head_pc         = pc_q[head_idx];
    assign head_pred_taken = pred_q[head_idx];
    assign head_value      = value_q[head_idx];
    assign head_target     = target_q[head_idx];
    assign head_addr       = addr_q[head_idx];

endmodule

// ==== logic/rob_commit.sv ====
`timescale 1ns/1ps

module rob_commit (
    input  logic                 alu_broadcast,
    input  logic                 rst_n,
    // head entry
    input  logic                 head_ready,
    input  rob_pkg::entry_kind_t head_kind,
    input  rob_pkg::reg_idx_t    head_rd,
    input  rob_pkg::mem_size_t   head_size,
    input  rob_pkg::xlen_t       head_pc,
    input  logic                 head_pred_taken,
    input  rob_pkg::xlen_t       head_value,
    input  rob_pkg::xlen_t       head_target,
    input  rob_pkg::xlen_t       head_addr,
    input  rob_pkg::rob_tag_t    head_tag,
    input  logic                 store_ready,
    // strobes back to pointers and table
    output logic                 retire,
    output logic                 flush,
    // register file
    output logic                 reg_commit_valid,
    output rob_pkg::reg_idx_t    reg_commit_rd,
    output rob_pkg::xlen_t       reg_commit_value,
    output rob_pkg::rob_tag_t    reg_commit_tag,
    // memory write
    output logic                 store_valid,
    output rob_pkg::xlen_t       store_addr,
    output rob_pkg::xlen_t       store_data,
    output rob_pkg::mem_size_t   store_size,
    // fetch redirect
    output logic                 redirect_valid,
    output rob_pkg::xlen_t       redirect_pc
);
    import rob_pkg::*;

    logic  commit_go;
    logic  is_reg;
    logic  is_store;
    logic  is_branch;
    logic  mispredict;
    logic  launch_store;
    logic  store_done;
    xlen_t fix_pc;

    // head may commit only while no store is out on the bus
    assign commit_go = head_ready && !store_valid;

    assign is_reg    = (head_kind == KIND_REG);
    assign is_store  = (head_kind == KIND_STORE);
    assign is_branch = (head_kind == KIND_BRANCH);

    // actual direction sits in bit 0 of the result
    assign mispredict = head_value[0] != head_pred_taken;

    assign launch_store = commit_go && is_store;
    assign store_done   = store_valid && store_ready;

    // wrong guess, go where the branch really went
    assign fix_pc = head_value[0] ? head_target : head_pc + 32'd4;

    assign flush = commit_go && is_branch && mispredict;

    // store retires on its handshake, not on launch
    // unknown kinds just drain so the buffer cannot lock up
    assign retire = (commit_go && !is_store && !flush) || store_done;

    always_ff @(posedge alu_broadcast or negedge rst_n) begin
        if (!rst_n) begin
            reg_commit_valid <= 1'b0;
            store_valid      <= 1'b0;
            redirect_valid   <= 1'b0;
        end else begin
            reg_commit_valid <= commit_go && is_reg;
            redirect_valid   <= flush;
            // held until memory takes it
            if (launch_store) begin
                store_valid <= 1'b1;
            end else if (store_done) begin
                store_valid <= 1'b0;
            end
        end
    end

    // payloads, only meaningful next to their valids
    always_ff @(posedge alu_broadcast) begin
        if (commit_go && is_reg) begin
            reg_commit_rd    <= head_rd;
            reg_commit_value <= head_value;
            reg_commit_tag   <= head_tag;
        end
        // fields frozen for the whole store handshake
        if (launch_store) begin
            store_addr <= head_addr;
            store_data <= head_value;
            store_size <= head_size;
        end
        if (flush) begin
            redirect_pc <= fix_pc;
        end
    end

endmodule

// ==== logic/rob_top.sv ====
`timescale 1ns/1ps

module rob_top #(
    parameter int DEPTH = rob_pkg::ROB_DEPTH
) (
    input  logic                 alu_broadcast,
    input  logic                 rst_n,
    // dispatch from decoder
    input  logic                 disp_valid,
    input  rob_pkg::entry_kind_t disp_kind,
    input  rob_pkg::reg_idx_t    disp_rd,
    input  rob_pkg::mem_size_t   disp_size,
    input  rob_pkg::xlen_t       disp_pc,
    input  logic                 disp_pred_taken,
    output logic                 disp_ready,
    output rob_pkg::rob_tag_t    disp_tag,
    // alu writeback
    input  logic                 alu_wb_valid,
    input  rob_pkg::rob_tag_t    alu_wb_tag,
    input  rob_pkg::xlen_t       alu_wb_value,
    input  rob_pkg::xlen_t       alu_wb_target,
    // lsb writeback
    input  logic                 lsb_wb_valid,
    input  rob_pkg::rob_tag_t    lsb_wb_tag,
    input  rob_pkg::xlen_t       lsb_wb_value,
    input  rob_pkg::xlen_t       lsb_wb_addr,
    // register commit
    output logic                 reg_commit_valid,
    output rob_pkg::reg_idx_t    reg_commit_rd,
    output rob_pkg::xlen_t       reg_commit_value,
    output rob_pkg::rob_tag_t    reg_commit_tag,
    // store commit
    output logic                 store_valid,
    output rob_pkg::xlen_t       store_addr,
    output rob_pkg::xlen_t       store_data,
    output rob_pkg::mem_size_t   store_size,
    input  logic                 store_ready,
    // redirect to fetch
    output logic                 redirect_valid,
    output rob_pkg::xlen_t       redirect_pc
);
    import rob_pkg::*;

    logic        disp_we;
    logic        retire;
    logic        flush;
    rob_tag_t    head_tag;
    logic        head_ready;
    entry_kind_t head_kind;
    reg_idx_t    head_rd;
    mem_size_t   head_size;
    xlen_t       head_pc;
    logic        head_pred_taken;
    xlen_t       head_value;
    xlen_t       head_target;
    xlen_t       head_addr;

    // accepted dispatch
    assign disp_we = disp_valid && disp_ready;

    // tail pointer is the tag handed to the decoder
    rob_alloc_ctrl #(
        .DEPTH (DEPTH)
    ) u_alloc (
        .alu_broadcast (alu_broadcast),
        .rst_n         (rst_n),
        .disp_valid    (disp_valid),
        .retire        (retire),
        .flush         (flush),
        .disp_ready    (disp_ready),
        .head_tag      (head_tag),
        .tail_tag      (disp_tag)
    );

    rob_entry_table #(
        .DEPTH (DEPTH)
    ) u_table (
        .alu_broadcast   (alu_broadcast),
        .rst_n           (rst_n),
        .disp_we         (disp_we),
        .tail_tag        (disp_tag),
        .disp_kind       (disp_kind),
        .disp_rd         (disp_rd),
        .disp_size       (disp_size),
        .disp_pc         (disp_pc),
        .disp_pred_taken (disp_pred_taken),
        .alu_wb_valid    (alu_wb_valid),
        .alu_wb_tag      (alu_wb_tag),
        .alu_wb_value    (alu_wb_value),
        .alu_wb_target   (alu_wb_target),
        .lsb_wb_valid    (lsb_wb_valid),
        .lsb_wb_tag      (lsb_wb_tag),
        .lsb_wb_value    (lsb_wb_value),
        .lsb_wb_addr     (lsb_wb_addr),
        .head_tag        (head_tag),
        .retire          (retire),
        .flush           (flush),
        .head_ready      (head_ready),
        .head_kind       (head_kind),
        .head_rd         (head_rd),
        .head_size       (head_size),
        .head_pc         (head_pc),
        .head_pred_taken (head_pred_taken),
        .head_value      (head_value),
        .head_target     (head_target),
        .head_addr       (head_addr)
    );

    rob_commit u_commit (
        .alu_broadcast    (alu_broadcast),
        .rst_n            (rst_n),
        .head_ready       (head_ready),
        .head_kind        (head_kind),
        .head_rd          (head_rd),
        .head_size        (head_size),
        .head_pc          (head_pc),
        .head_pred_taken  (head_pred_taken),
        .head_value       (head_value),
        .head_target      (head_target),
        .head_addr        (head_addr),
        .head_tag         (head_tag),
        .store_ready      (store_ready),
        .retire           (retire),
        .flush            (flush),
        .reg_commit_valid (reg_commit_valid),
        .reg_commit_rd    (reg_commit_rd),
        .reg_commit_value (reg_commit_value),
        .reg_commit_tag   (reg_commit_tag),
        .store_valid      (store_valid),
        .store_addr       (store_addr),
        .store_data       (store_data),
        .store_size       (store_size),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc)
    );

endmodule

// ==== bench/rob_checker.sv ====
`timescale 1ns/1ps

module rob_checker #(
    parameter int DEPTH = 8
) (
    input logic        alu_broadcast,
    input logic        rst_n,
    input logic        disp_valid,
    input logic        disp_ready,
    input logic [3:0]  disp_tag,
    input logic        reg_commit_valid,
    input logic [4:0]  reg_commit_rd,
    input logic [31:0] reg_commit_value,
    input logic [3:0]  reg_commit_tag,
    input logic        store_valid,
    input logic        store_ready,
    input logic [31:0] store_addr,
    input logic [31:0] store_data,
    input logic [1:0]  store_size,
    input logic        redirect_valid,
    input logic [31:0] redirect_pc,
    output int         val_errs,
    output int         other_errs
);
    // expected commit events in program order, R S or F
    byte         q_kind [$];
    logic [31:0] q_a [$];
    logic [31:0] q_b [$];
    logic [31:0] q_c [$];
    int          exp_tag;
    bit          reset_checked;

    initial begin
        val_errs      = 0;
        other_errs    = 0;
        exp_tag       = 0;
        reset_checked = 0;
    end

    task automatic expect_event(input byte k, input logic [31:0] a, b, c);
        q_kind.push_back(k);
        q_a.push_back(a);
        q_b.push_back(b);
        q_c.push_back(c);
    endtask

    function automatic int pending();
        return q_kind.size();
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, got);
        if (exp !== got) begin
            val_errs++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // called between edges, level is stable there
    task automatic expect_ready(input logic v);
        compare("disp_ready", 32'(v), 32'(disp_ready));
    endtask

    task automatic match_event(input byte k, input string n1, input logic [31:0] g1,
                               input string n2, input logic [31:0] g2,
                               input string n3, input logic [31:0] g3);
        byte         ek;
        logic [31:0] ea;
        logic [31:0] eb;
        logic [31:0] ec;
        if (q_kind.size() == 0) begin
            other_errs++;
            $display("%0t: commit of kind %c seen but none was expected", $time, k);
            return;
        end
        ek = q_kind.pop_front();
        ea = q_a.pop_front();
        eb = q_b.pop_front();
        ec = q_c.pop_front();
        if (ek != k) begin
            other_errs++;
            $display("%0t: commit out of order, expected kind %c but got %c", $time, ek, k);
            return;
        end
        compare(n1, ea, g1);
        if (n2 != "") compare(n2, eb, g2);
        if (n3 != "") compare(n3, ec, g3);
    endtask

    always @(posedge alu_broadcast) begin
        if (!rst_n) begin
            exp_tag = 0;
        end else begin
            // first edge out of reset
            if (!reset_checked) begin
                reset_checked = 1;
                compare("reg_commit_valid", 32'd0, 32'(reg_commit_valid));
                compare("store_valid", 32'd0, 32'(store_valid));
                compare("redirect_valid", 32'd0, 32'(redirect_valid));
                compare("disp_ready", 32'd1, 32'(disp_ready));
            end
            if (reg_commit_valid)
                match_event("R", "reg_commit_rd", 32'(reg_commit_rd),
                            "reg_commit_value", reg_commit_value,
                            "reg_commit_tag", 32'(reg_commit_tag));
            // store counts on its handshake edge only
            if (store_valid && store_ready)
                match_event("S", "store_addr", store_addr, "store_data", store_data,
                            "store_size", 32'(store_size));
            if (redirect_valid) begin
                match_event("F", "redirect_pc", redirect_pc, "", 0, "", 0);
                // buffer emptied, tags restart
                exp_tag = 0;
            end
            if (disp_valid && disp_ready) begin
                compare("disp_tag", 32'(exp_tag), 32'(disp_tag));
                exp_tag = (exp_tag + 1) % DEPTH;
            end
        end
    end

endmodule

// ==== bench/rob_asserts.sv ====
`timescale 1ns/1ps

module rob_asserts (
    input logic        alu_broadcast,
    input logic        rst_n,
    input logic        store_valid,
    input logic        store_ready,
    input logic [31:0] store_addr,
    input logic [31:0] store_data,
    input logic [1:0]  store_size,
    input logic        reg_commit_valid,
    input logic        redirect_valid
);
    // stalled store keeps its request and fields
    a_store_hold: assert property (@(posedge alu_broadcast) disable iff (!rst_n)
        store_valid && !store_ready |=> store_valid && $stable(store_addr)
            && $stable(store_data) && $stable(store_size))
        else $error("store fields changed while stalled");

    // redirect is a single pulse
    a_redirect_pulse: assert property (@(posedge alu_broadcast) disable iff (!rst_n)
        redirect_valid |=> !redirect_valid)
        else $error("redirect_valid held two cycles");

    a_no_overlap: assert property (@(posedge alu_broadcast) disable iff (!rst_n)
        !(reg_commit_valid && redirect_valid))
        else $error("register commit together with redirect");

endmodule

bind rob_commit rob_asserts u_asserts (
    .alu_broadcast    (alu_broadcast),
    .rst_n            (rst_n),
    .store_valid      (store_valid),
    .store_ready      (store_ready),
    .store_addr       (store_addr),
    .store_data       (store_data),
    .store_size       (store_size),
    .reg_commit_valid (reg_commit_valid),
    .redirect_valid   (redirect_valid)
);

// ==== bench/rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb;
    import rob_pkg::*;

    localparam int DEPTH = ROB_DEPTH;

    logic        alu_broadcast;
    logic        rst_n;
    logic        disp_valid;
    entry_kind_t disp_kind;
    reg_idx_t    disp_rd;
    mem_size_t   disp_size;
    xlen_t       disp_pc;
    logic        disp_pred_taken;
    logic        disp_ready;
    rob_tag_t    disp_tag;
    logic        alu_wb_valid;
    rob_tag_t    alu_wb_tag;
    xlen_t       alu_wb_value;
    xlen_t       alu_wb_target;
    logic        lsb_wb_valid;
    rob_tag_t    lsb_wb_tag;
    xlen_t       lsb_wb_value;
    xlen_t       lsb_wb_addr;
    logic        reg_commit_valid;
    reg_idx_t    reg_commit_rd;
    xlen_t       reg_commit_value;
    rob_tag_t    reg_commit_tag;
    logic        store_valid;
    xlen_t       store_addr;
    xlen_t       store_data;
    mem_size_t   store_size;
    logic        store_ready;
    logic        redirect_valid;
    xlen_t       redirect_pc;
    int          val_errs;
    int          other_errs;

    string       lines [$];
    int          cycles;
    int          limit;
    int unsigned lcg_state;

    rob_top #(.DEPTH(DEPTH)) UUT (.*);

    rob_checker #(.DEPTH(DEPTH)) u_check (
        .alu_broadcast, .rst_n, .disp_valid, .disp_ready, .disp_tag,
        .reg_commit_valid, .reg_commit_rd, .reg_commit_value, .reg_commit_tag,
        .store_valid, .store_ready, .store_addr, .store_data, .store_size,
        .redirect_valid, .redirect_pc, .val_errs, .other_errs
    );

    initial begin
        alu_broadcast = 0;
        forever #2 alu_broadcast = ~alu_broadcast;
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // memory back-pressure stalls roughly half the cycles
    initial lcg_state = 17;
    always @(negedge alu_broadcast) begin
        lcg_state   = lcg_next(lcg_state);
        store_ready = lcg_state[16];
    end

    // watchdog sized from the case file length
    initial cycles = 0;
    initial limit = 0;
    always @(posedge alu_broadcast) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("run stopped after %0d cycles, DUT stopped making progress", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic run_line(input string line);
        byte         t;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        void'($sscanf(line, "%c %h %h %h %h %h", t, f1, f2, f3, f4, f5));
        case (t)
            "D": begin
                @(negedge alu_broadcast);
                while (!disp_ready) @(negedge alu_broadcast);
                disp_valid      = 1;
                disp_kind       = entry_kind_t'(f1[1:0]);
                disp_rd         = f2[4:0];
                disp_size       = mem_size_t'(f3[1:0]);
                disp_pc         = f4;
                disp_pred_taken = f5[0];
                @(negedge alu_broadcast);
                disp_valid = 0;
            end
            "A": begin
                @(negedge alu_broadcast);
                alu_wb_valid  = 1;
                alu_wb_tag    = f1[3:0];
                alu_wb_value  = f2;
                alu_wb_target = f3;
                @(negedge alu_broadcast);
                alu_wb_valid = 0;
            end
            "L": begin
                @(negedge alu_broadcast);
                lsb_wb_valid = 1;
                lsb_wb_tag   = f1[3:0];
                lsb_wb_value = f2;
                lsb_wb_addr  = f3;
                @(negedge alu_broadcast);
                lsb_wb_valid = 0;
            end
            "N": repeat (f1) @(negedge alu_broadcast);
            "P": begin
                @(negedge alu_broadcast);
                u_check.expect_ready(f1[0]);
            end
            // expected records take no time
            "R", "S", "F": u_check.expect_event(t, f1, f2, f3);
            default: ;
        endcase
    endtask

    initial begin
        int    fd;
        string s;
        rst_n = 0;
        disp_valid = 0;
        disp_kind = KIND_REG;
        disp_rd = '0;
        disp_size = SIZE_B;
        disp_pc = '0;
        disp_pred_taken = 0;
        alu_wb_valid = 0;
        alu_wb_tag = '0;
        alu_wb_value = '0;
        alu_wb_target = '0;
        lsb_wb_valid = 0;
        lsb_wb_tag = '0;
        lsb_wb_value = '0;
        lsb_wb_addr = '0;
        store_ready = 0;
        fd = $fopen("bench/rob_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/rob_cases.txt");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            while ($fgets(s, fd) != 0) begin
                if (s.len() > 1 && s[0] != "#") lines.push_back(s);
            end
            $fclose(fd);
            limit = 20 * lines.size() + 200;
            repeat (16) @(posedge alu_broadcast);
            @(negedge alu_broadcast);
            rst_n = 1;
            foreach (lines[i]) run_line(lines[i]);
            while (u_check.pending() != 0) @(negedge alu_broadcast);
            repeat (10) @(negedge alu_broadcast);
            $display("errors: %0d value, %0d other", val_errs, other_errs);
            if (val_errs == 0 && other_errs == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== bench/rob_cases.txt ====
# D kind rd size pc pred | A tag value target | L tag value addr | N cycles
# R rd value tag | S addr data size | F pc | P disp_ready level (all hex)
# in-order register commit, writebacks out of order
R 01 00000111 0
R 02 00000222 1
R 03 00000333 2
D 0 01 0 00000100 0
D 0 02 0 00000104 0
D 0 03 0 00000108 0
A 2 00000333 00000000
A 0 00000111 00000000
L 1 00000222 00000000
N 4
# byte, half, word stores, then a register entry held behind them
S 00001000 000000aa 0
S 00001002 0000bbbb 1
S 00001004 cccccccc 2
R 04 00000444 6
D 1 00 0 00000200 0
D 1 00 1 00000204 0
D 1 00 2 00000208 0
D 0 04 0 0000020c 0
A 6 00000444 00000000
L 4 0000bbbb 00001002
L 3 000000aa 00001000
L 5 cccccccc 00001004
N 20
# fill all entries, stall, free one, wrap tags
R 0a 000000a0 7
D 0 0a 0 00000300 0
D 0 0b 0 00000304 0
D 0 0c 0 00000308 0
D 0 0d 0 0000030c 0
D 0 0e 0 00000310 0
D 0 0f 0 00000314 0
D 0 10 0 00000318 0
D 0 11 0 0000031c 0
P 0
A 7 000000a0 00000000
N 3
P 1
R 0b 000000b0 0
R 0c 000000c0 1
R 0d 000000d0 2
R 0e 000000e0 3
R 0f 000000f0 4
R 10 00000100 5
R 11 00000110 6
R 12 00000120 7
D 0 12 0 00000320 0
A 7 00000120 00000000
A 6 00000110 00000000
A 5 00000100 00000000
A 4 000000f0 00000000
A 3 000000e0 00000000
A 2 000000d0 00000000
A 1 000000c0 00000000
A 0 000000b0 00000000
N 4
# correct branch, then taken mispredict with a younger entry
R 05 00000555 1
F 00000500
D 2 00 0 00000400 1
A 0 00000001 00000480
D 0 05 0 00000404 0
A 1 00000555 00000000
D 2 00 0 00000408 0
D 0 06 0 0000040c 0
A 3 00000666 00000000
A 2 00000001 00000500
N 4
# not-taken mispredict, restart at tag 0
F 00000604
R 07 00000777 0
D 2 00 0 00000600 1
A 0 00000000 00000700
N 4
D 0 07 0 00000610 0
A 0 00000777 00000000
N 10

// ==== all.f ====
logic/rob_pkg.sv
logic/rob_alloc_ctrl.sv
logic/rob_entry_table.sv
logic/rob_commit.sv
logic/rob_top.sv
bench/rob_checker.sv
bench/rob_asserts.sv
bench/rob_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= rob_tb
FILELIST  ?= all.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
